//--- design/sifhPkg.sv
package sifhPkg;

    // pixel group size
    localparam int PIXEL_NUM = 4;
    // bins in one pixel histogram
    localparam int BIN_NUM = 16;

    // index widths
    localparam int PIXEL_WIDTH = $clog2(PIXEL_NUM);
    localparam int BIN_WIDTH = $clog2(BIN_NUM);

    // raw tdc timestamp width
    localparam int TS_WIDTH = 10;

    // counter width, saturates at all ones
    localparam int COUNT_WIDTH = 8;

    // one entry per pixel and bin
    localparam int HIST_DEPTH = PIXEL_NUM * BIN_NUM;

    // photon event as it arrives from the tdc side
    typedef struct packed {
        logic [PIXEL_WIDTH-1:0] pixel;
        logic [TS_WIDTH-1:0] timestamp;
    } photonT;

    // histogram address, pixel in the upper bits
    // so incrementing walks pixel-major
    typedef struct packed {
        logic [PIXEL_WIDTH-1:0] pixel;
        logic [BIN_WIDTH-1:0] bin;
    } binAddrT;

    // per pixel peak report
    typedef struct packed {
        logic [PIXEL_WIDTH-1:0] pixel;
        logic [BIN_WIDTH-1:0] bin;
        logic [COUNT_WIDTH-1:0] count;
    } peakT;

endpackage

//--- design/binQuantizer.sv
`timescale 1ns/1ps

module binQuantizer #(
    // log2 of the bin width in tdc ticks
    parameter int BIN_SHIFT = 2
) (
    input  logic clk,
    input  logic res,
    input  logic photonValid,
    input  sifhPkg::photonT photon,
    input  logic [sifhPkg::TS_WIDTH-1:0] windowStart,
    input  logic scanning,
    output logic binAddrValid,
    output sifhPkg::binAddrT binAddr
);

    // time since window opened
    logic [sifhPkg::TS_WIDTH-1:0] offset;
    // offset in bin units
    logic [sifhPkg::TS_WIDTH-1:0] scaled;
    logic belowWindow;
    logic aboveWindow;
    logic accept;

    always_comb begin
        offset = photon.timestamp - windowStart;
        scaled = offset >> BIN_SHIFT;
        // subtraction wrapped, photon came before the window
        belowWindow = photon.timestamp < windowStart;
        // any bit above the bin index means past the last bin
        aboveWindow = |scaled[sifhPkg::TS_WIDTH-1:sifhPkg::BIN_WIDTH];
        // histogram is frozen while the peak finder runs
        accept = photonValid && !scanning && !belowWindow && !aboveWindow;
    end

    // strobe out one cycle after the photon
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binAddrValid <= 1'b0;
        end else begin
            binAddrValid <= accept;
        end
    end

    // address only loaded on accepted events
    always_ff @(posedge clk) begin
        if (accept) begin
            binAddr.pixel <= photon.pixel;
            binAddr.bin <= scaled[sifhPkg::BIN_WIDTH-1:0];
        end
    end

endmodule

//--- design/histBuilder.sv
`timescale 1ns/1ps

module histBuilder (
    input  logic clk,
    input  logic res,
    input  logic binAddrValid,
    input  sifhPkg::binAddrT binAddr,
    input  logic [sifhPkg::COUNT_WIDTH-1:0] rdDataA,
    output sifhPkg::binAddrT rdAddrA,
    output logic wrEn,
    output sifhPkg::binAddrT wrAddr,
    output logic [sifhPkg::COUNT_WIDTH-1:0] wrData
);

    localparam logic [sifhPkg::COUNT_WIDTH-1:0] COUNT_ONE = 1;

    // stage 1 to stage 2 pipeline
    logic s1Valid;
    sifhPkg::binAddrT s1Addr;

    // last written entry, covers the write still on its way into the ram
    logic fwdValid;
    sifhPkg::binAddrT fwdAddr;
    logic [sifhPkg::COUNT_WIDTH-1:0] fwdData;

    // count before the increment
    logic [sifhPkg::COUNT_WIDTH-1:0] baseCount;
    logic fwdHit;

    // stage 1
    // read address goes straight to the ram, data back next cycle
    assign rdAddrA = binAddr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= binAddrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (binAddrValid) begin
            s1Addr <= binAddr;
        end
    end

    // stage 2
    // ram read was issued before the previous write landed,
    // so a back to back hit must take the forwarded value
    always_comb begin
        fwdHit = fwdValid && (fwdAddr == s1Addr);
        if (fwdHit) begin
            baseCount = fwdData;
        end else begin
            baseCount = rdDataA;
        end
    end

    // saturating increment
    always_comb begin
        wrEn = s1Valid;
        wrAddr = s1Addr;
        if (baseCount == '1) begin
            wrData = baseCount;
        end else begin
            wrData = baseCount + COUNT_ONE;
        end
    end

    // forward window is exactly one cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            fwdValid <= 1'b0;
        end else begin
            fwdValid <= wrEn;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            fwdAddr <= wrAddr;
            fwdData <= wrData;
        end
    end

endmodule

//--- design/histRam.sv
`timescale 1ns/1ps

module histRam (
    input  logic clk,
    input  logic res,
    input  logic wrEn,
    input  sifhPkg::binAddrT wrAddr,
    input  logic [sifhPkg::COUNT_WIDTH-1:0] wrData,
    input  sifhPkg::binAddrT rdAddrA,
    input  sifhPkg::binAddrT rdAddrB,
    input  logic clear,
    output logic [sifhPkg::COUNT_WIDTH-1:0] rdDataA,
    output logic [sifhPkg::COUNT_WIDTH-1:0] rdDataB
);

    // one counter per pixel and bin, pixel-major
    logic [sifhPkg::COUNT_WIDTH-1:0] mem [sifhPkg::HIST_DEPTH];

    // write port
    // clear wins over a write in the same cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < sifhPkg::HIST_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (clear) begin
            // whole array in one edge, ready for next frame
            for (int i = 0; i < sifhPkg::HIST_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // port a for the builder, port b for the peak finder
    // both registered, old data on a same cycle write
    always_ff @(posedge clk) begin
        rdDataA <= mem[rdAddrA];
        rdDataB <= mem[rdAddrB];
    end

endmodule

//--- design/peakFinder.sv
`timescale 1ns/1ps

module peakFinder (
    input  logic clk,
    input  logic res,
    input  logic frameEnd,
    input  logic [sifhPkg::COUNT_WIDTH-1:0] rdDataB,
    output sifhPkg::binAddrT rdAddrB,
    output logic clear,
    output logic scanning,
    output logic peakValid,
    output sifhPkg::peakT peak,
    output logic frameDone
);

    typedef enum logic [1:0] {
        IDLE,
        DRAIN,
        SCAN,
        DONE
    } stateT;

    stateT state;
    // second drain cycle flag
    logic drainCnt;
    // walks pixel-major, bin is the low field
    sifhPkg::binAddrT scanAddr;

    // ram data lines up with this one cycle after the read
    logic dataValid;
    sifhPkg::binAddrT dataAddr;

    // running max of the pixel being scanned
    logic [sifhPkg::COUNT_WIDTH-1:0] maxCount;
    logic [sifhPkg::BIN_WIDTH-1:0] maxBin;
    // max including the count just returned
    logic [sifhPkg::COUNT_WIDTH-1:0] curCount;
    logic [sifhPkg::BIN_WIDTH-1:0] curBin;

    // control FSM
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
            drainCnt <= 1'b0;
            scanAddr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // frameEnd only seen here, ignored mid scan
                    if (frameEnd) begin
                        state <= DRAIN;
                        drainCnt <= 1'b0;
                    end
                end
                DRAIN: begin
                    // two cycles so in flight increments reach the ram
                    drainCnt <= 1'b1;
                    if (drainCnt) begin
                        state <= SCAN;
                    end
                end
                SCAN: begin
                    // one read per cycle, wraps back to zero at the end
                    scanAddr <= sifhPkg::binAddrT'(scanAddr + 1'b1);
                    if (scanAddr == '1) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign rdAddrB = scanAddr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            dataValid <= 1'b0;
        end else begin
            dataValid <= (state == SCAN);
        end
    end

    always_ff @(posedge clk) begin
        dataAddr <= scanAddr;
    end

    // bin 0 restarts the max
    // strict greater keeps the lowest bin on a tie
    always_comb begin
        if ((dataAddr.bin == '0) || (rdDataB > maxCount)) begin
            curCount = rdDataB;
            curBin = dataAddr.bin;
        end else begin
            curCount = maxCount;
            curBin = maxBin;
        end
    end

    always_ff @(posedge clk) begin
        if (dataValid) begin
            maxCount <= curCount;
            maxBin <= curBin;
        end
    end

    // report on the last bin of each pixel
    always_comb begin
        peakValid = dataValid && (dataAddr.bin == '1);
        peak.pixel = dataAddr.pixel;
        peak.bin = curBin;
        peak.count = curCount;
    end

    // DONE lines up with the last pixel's report
    assign frameDone = (state == DONE);
    assign clear = (state == DONE);
    assign scanning = (state != IDLE);

endmodule

//--- design/histogramTop.sv
`timescale 1ns/1ps

module histogramTop #(
    // bin width is 2**BIN_SHIFT tdc ticks
    parameter int BIN_SHIFT = 2
) (
    input  logic clk,
    input  logic res,
    input  logic photonValid,
    input  sifhPkg::photonT photon,
    input  logic [sifhPkg::TS_WIDTH-1:0] windowStart,
    input  logic frameEnd,
    output logic peakValid,
    output sifhPkg::peakT peak,
    output logic frameDone,
    output logic scanning
);

    // quantizer to builder
    logic binAddrValid;
    sifhPkg::binAddrT binAddr;

    // builder side of the ram
    sifhPkg::binAddrT rdAddrA;
    logic [sifhPkg::COUNT_WIDTH-1:0] rdDataA;
    logic wrEn;
    sifhPkg::binAddrT wrAddr;
    logic [sifhPkg::COUNT_WIDTH-1:0] wrData;

    // peak finder side of the ram
    sifhPkg::binAddrT rdAddrB;
    logic [sifhPkg::COUNT_WIDTH-1:0] rdDataB;
    logic clear;

    binQuantizer #(
        .BIN_SHIFT(BIN_SHIFT)
    ) binQuantizer_i (
        .clk(clk),
        .res(res),
        .photonValid(photonValid),
        .photon(photon),
        .windowStart(windowStart),
        .scanning(scanning),
        .binAddrValid(binAddrValid),
        .binAddr(binAddr)
    );

    histBuilder histBuilder_i (
        .clk(clk),
        .res(res),
        .binAddrValid(binAddrValid),
        .binAddr(binAddr),
        .rdDataA(rdDataA),
        .rdAddrA(rdAddrA),
        .wrEn(wrEn),
        .wrAddr(wrAddr),
        .wrData(wrData)
    );

    histRam histRam_i (
        .clk(clk),
        .res(res),
        .wrEn(wrEn),
        .wrAddr(wrAddr),
        .wrData(wrData),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .clear(clear),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB)
    );

    peakFinder peakFinder_i (
        .clk(clk),
        .res(res),
        .frameEnd(frameEnd),
        .rdDataB(rdDataB),
        .rdAddrB(rdAddrB),
        .clear(clear),
        .scanning(scanning),
        .peakValid(peakValid),
        .peak(peak),
        .frameDone(frameDone)
    );

endmodule

//--- verif/histogramTopTb.sv
`timescale 1ns/1ps

module histogramTopTb;

    localparam int BIN_SHIFT = 2;
    localparam int WIN_START = 100;
    // drain, one read per entry, done cycle
    localparam int SCAN_CYCLES = 3 + sifhPkg::HIST_DEPTH;
    localparam logic [1:0] PHOTON = 2'd0;
    localparam logic [1:0] RANDOM = 2'd1;
    localparam logic [1:0] FRAME = 2'd2;
    localparam logic [1:0] WINDOW = 2'd3;

    // one table row, rep photons with an optional idle cycle before each
    typedef struct packed {
        logic [3:0] test;
        logic [1:0] kind;
        logic [sifhPkg::PIXEL_WIDTH-1:0] pixel;
        logic [sifhPkg::TS_WIDTH-1:0] ts;
        logic gap;
        logic [8:0] rep;
    } rowT;

    logic clk = 1'b0;
    logic res;
    logic photonValid;
    sifhPkg::photonT photon;
    logic [sifhPkg::TS_WIDTH-1:0] windowStart;
    logic frameEnd;
    logic peakValid;
    sifhPkg::peakT peak;
    logic frameDone;
    logic scanning;

    rowT rows[$];
    sifhPkg::peakT expQ[$];
    // reference histogram
    logic [sifhPkg::COUNT_WIDTH-1:0] model [sifhPkg::PIXEL_NUM][sifhPkg::BIN_NUM];
    string testNames[6] = '{"isolated photons", "back to back burst", "window edges",
        "saturation", "tie and empty pixel", "frame isolation"};

    integer seed = 47;
    // window start the model currently applies
    int winStart = WIN_START;
    int curCycle = 0;
    int feCycle = -1000;
    int framesSent = 0;
    int doneCount = 0;
    int errCount = 0;
    int peaksChecked = 0;
    int cycleCount = 0;
    int cycleLimit = 10;

    histogramTop #(
        .BIN_SHIFT(BIN_SHIFT)
    ) histogramTop_i (
        .clk(clk),
        .res(res),
        .photonValid(photonValid),
        .photon(photon),
        .windowStart(windowStart),
        .frameEnd(frameEnd),
        .peakValid(peakValid),
        .peak(peak),
        .frameDone(frameDone),
        .scanning(scanning)
    );

    always #10 clk = ~clk;

    task automatic addRow(input int test, input logic [1:0] kind, input int pixel,
                          input int ts, input int gap, input int rep);
        rowT r;
        r.test = test[3:0];
        r.kind = kind;
        r.pixel = pixel[sifhPkg::PIXEL_WIDTH-1:0];
        r.ts = ts[sifhPkg::TS_WIDTH-1:0];
        r.gap = gap[0];
        r.rep = rep[8:0];
        rows.push_back(r);
        // budget for the timeout
        if (kind == FRAME) begin
            cycleLimit += 100;
        end else begin
            cycleLimit += rep * (1 + gap) + 1;
        end
    endtask

    // window 100..163, bin b starts at 100 + 4b
    task automatic buildTable;
        addRow(1, PHOTON, 0, 112, 1, 3);
        addRow(1, PHOTON, 0, 121, 1, 1);
        addRow(1, PHOTON, 1, 140, 1, 2);
        addRow(1, PHOTON, 2, 160, 1, 4);
        addRow(1, PHOTON, 3, 101, 1, 1);
        addRow(1, RANDOM, 0, 0, 1, 8);
        addRow(1, FRAME, 0, 0, 0, 1);
        // same bin every cycle, then a neighbour right behind it
        addRow(2, PHOTON, 1, 130, 0, 12);
        addRow(2, PHOTON, 1, 134, 0, 1);
        addRow(2, PHOTON, 2, 150, 1, 3);
        addRow(2, FRAME, 0, 0, 0, 1);
        addRow(3, PHOTON, 0, 99, 1, 2);
        addRow(3, PHOTON, 0, 164, 1, 2);
        addRow(3, PHOTON, 0, 1023, 1, 1);
        addRow(3, PHOTON, 0, 100, 1, 1);
        addRow(3, PHOTON, 0, 163, 1, 2);
        addRow(3, PHOTON, 1, 0, 1, 1);
        addRow(3, PHOTON, 2, 167, 0, 3);
        // window near the top, a wrapped offset of ts 30 falls in bin 13
        addRow(3, WINDOW, 0, 1000, 0, 1);
        addRow(3, PHOTON, 1, 30, 1, 1);
        addRow(3, WINDOW, 0, WIN_START, 0, 1);
        addRow(3, FRAME, 0, 0, 0, 1);
        addRow(4, PHOTON, 3, 150, 0, 300);
        addRow(4, FRAME, 0, 0, 0, 1);
        // pixel 2 stays empty
        addRow(5, PHOTON, 0, 116, 0, 3);
        addRow(5, PHOTON, 0, 136, 0, 3);
        addRow(5, PHOTON, 1, 108, 1, 2);
        addRow(5, PHOTON, 1, 104, 1, 2);
        addRow(5, PHOTON, 3, 128, 1, 1);
        addRow(5, FRAME, 0, 0, 0, 1);
        addRow(6, PHOTON, 2, 110, 1, 5);
        addRow(6, FRAME, 0, 0, 0, 1);
        // lands inside the scan
        addRow(6, PHOTON, 2, 110, 0, 20);
        addRow(6, WINDOW, 0, WIN_START, 0, 1);
        addRow(6, PHOTON, 2, 130, 1, 2);
        addRow(6, PHOTON, 0, 100, 1, 1);
        addRow(6, FRAME, 0, 0, 0, 1);
    endtask

    // strobes fall back low unless driven again in this cycle
    task automatic tick;
        logic expScan;
        @(posedge clk);
        // level of the cycle that just ended, high from the cycle after frameEnd
        expScan = (curCycle > feCycle) && (curCycle <= feCycle + SCAN_CYCLES);
        if (scanning !== expScan) begin
            $display("Mismatch at %0t: scanning expected %0d got %0d",
                     $time, expScan, scanning);
            errCount++;
        end
        curCycle++;
        photonValid <= 1'b0;
        frameEnd <= 1'b0;
    endtask

    task automatic countPhoton(input int pixel, input int ts);
        int bin;
        bin = (ts - winStart) >> BIN_SHIFT;
        // gate closed from the cycle after frameEnd to frameDone
        if (curCycle > feCycle && curCycle <= feCycle + SCAN_CYCLES) begin
            return;
        end
        if (ts < winStart || bin >= sifhPkg::BIN_NUM) begin
            return;
        end
        if (model[pixel][bin] != '1) begin
            model[pixel][bin] = model[pixel][bin] + 1'b1;
        end
    endtask

    task automatic drivePhoton(input int pixel, input int ts);
        tick();
        photonValid <= 1'b1;
        photon.pixel <= pixel[sifhPkg::PIXEL_WIDTH-1:0];
        photon.timestamp <= ts[sifhPkg::TS_WIDTH-1:0];
        countPhoton(pixel, ts);
    endtask

    // expected peaks, then the model starts the next frame empty
    task automatic expectFrame;
        sifhPkg::peakT p;
        for (int px = 0; px < sifhPkg::PIXEL_NUM; px++) begin
            p.pixel = px[sifhPkg::PIXEL_WIDTH-1:0];
            p.bin = '0;
            p.count = model[px][0];
            // strictly larger only, lowest bin kept on a tie
            for (int b = 1; b < sifhPkg::BIN_NUM; b++) begin
                if (model[px][b] > p.count) begin
                    p.bin = b[sifhPkg::BIN_WIDTH-1:0];
                    p.count = model[px][b];
                end
            end
            expQ.push_back(p);
            for (int b = 0; b < sifhPkg::BIN_NUM; b++) begin
                model[px][b] = '0;
            end
        end
    endtask

    task automatic waitFrames;
        while (doneCount != framesSent) begin
            tick();
        end
    endtask

    task automatic finishTest(input int test, input int errBefore);
        waitFrames();
        if (expQ.size() != 0) begin
            $display("test %0d: %0d peak results never arrived", test, expQ.size());
            errCount++;
            expQ.delete();
        end
        $display("test %0d %s: %s", test, testNames[test-1],
                 (errCount == errBefore) ? "ok" : "errors");
    endtask

    // stimulus
    initial begin
        int curTest;
        int errBefore;
        int rnd;
        rowT r;
        res = 1'b0;
        photonValid = 1'b0;
        photon = '0;
        windowStart = WIN_START[sifhPkg::TS_WIDTH-1:0];
        frameEnd = 1'b0;
        // ram comes out of reset all zero
        for (int px = 0; px < sifhPkg::PIXEL_NUM; px++) begin
            for (int b = 0; b < sifhPkg::BIN_NUM; b++) begin
                model[px][b] = '0;
            end
        end
        buildTable();
        repeat (2) @(posedge clk);
        res <= 1'b1;
        curTest = int'(rows[0].test);
        errBefore = 0;
        foreach (rows[i]) begin
            r = rows[i];
            if (int'(r.test) != curTest) begin
                finishTest(curTest, errBefore);
                curTest = int'(r.test);
                errBefore = errCount;
            end
            case (r.kind)
                PHOTON, RANDOM: begin
                    for (int n = 0; n < int'(r.rep); n++) begin
                        if (r.gap) begin
                            tick();
                        end
                        if (r.kind == RANDOM) begin
                            // background, a few fall below the window
                            rnd = $random(seed);
                            drivePhoton(rnd & (sifhPkg::PIXEL_NUM - 1),
                                        ((rnd >> 8) & 63) + WIN_START - 4);
                        end else begin
                            drivePhoton(int'(r.pixel), int'(r.ts));
                        end
                    end
                end
                FRAME: begin
                    waitFrames();
                    tick();
                    frameEnd <= 1'b1;
                    feCycle = curCycle;
                    framesSent++;
                    expectFrame();
                end
                default: begin
                    // idle first, last photon keeps the old window
                    waitFrames();
                    tick();
                    windowStart <= r.ts;
                    winStart = int'(r.ts);
                end
            endcase
        end
        tick();
        finishTest(curTest, errBefore);
        $display("tests %0d, frames %0d, peaks checked %0d, errors %0d",
                 curTest, framesSent, peaksChecked, errCount);
        if (errCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // result monitor
    always @(posedge clk) begin
        sifhPkg::peakT want;
        if (frameDone) begin
            doneCount <= doneCount + 1;
        end
        if (peakValid) begin
            if (expQ.size() == 0) begin
                $display("peak result for pixel %0d at %0t with no frame pending",
                         peak.pixel, $time);
                errCount++;
            end else begin
                want = expQ.pop_front();
                peaksChecked++;
                if (peak.pixel != want.pixel) begin
                    $display("Mismatch at %0t: peak.pixel expected %0d got %0d",
                             $time, want.pixel, peak.pixel);
                    errCount++;
                end
                if (peak.bin != want.bin) begin
                    $display("Mismatch at %0t: peak.bin expected %0d got %0d",
                             $time, want.bin, peak.bin);
                    errCount++;
                end
                if (peak.count != want.count) begin
                    $display("Mismatch at %0t: peak.count expected %0d got %0d",
                             $time, want.count, peak.count);
                    errCount++;
                end
                // frameDone rides with the last pixel only
                if (want.pixel == '1 && !frameDone) begin
                    $display("frameDone missing with the last pixel's peak at %0t", $time);
                    errCount++;
                end
                if (want.pixel != '1 && frameDone) begin
                    $display("frameDone pulsed before the last pixel's peak at %0t", $time);
                    errCount++;
                end
            end
        end else if (frameDone) begin
            $display("frameDone pulsed without a peak result at %0t", $time);
            errCount++;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout after %0d cycles, %0d of %0d frames finished",
                     cycleCount, doneCount, framesSent);
            $display("STATUS: FAIL");
            $finish;
        end
    end

endmodule

//--- histogramTop.f
design/sifhPkg.sv
design/binQuantizer.sv
design/histBuilder.sv
design/histRam.sv
design/peakFinder.sv
design/histogramTop.sv
verif/histogramTopTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing -j 0
TOP = histogramTopTb
FILELIST = histogramTop.f
BUILD = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
